// File: sim.f
rtl/tile_pkg.sv
rtl/feature_ram.sv
rtl/tile_scheduler.sv
rtl/tile_fetcher.sv
rtl/tile_stream_top.sv
bench/tile_props.sv
bench/tile_checker.sv
bench/tb_top.sv

// File: run.sh
#!/bin/sh
# Builds and runs the testbench with Verilator. Exits non-zero unless the pass message appears.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_top -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb +verilator+error+limit+1000)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1

// File: bench/tb_top.sv
// Three runs: out_ready held high, random back-pressure, then a reload with loads and starts sent while busy.
module tb_top import tile_pkg::*; ();

    localparam int NUM_TESTS = 3;
    localparam int RUN_TILES = 100;
    localparam int PERIOD    = 20;
    // Four cycles per element is a generous bound even at 60% ready.
    localparam int LIMIT = NUM_TESTS * RUN_TILES * TILE_ELEMS * 4 * PERIOD +
                           NUM_TESTS * RAM_DEPTH * PERIOD + 20 * PERIOD;

    logic          clk;
    logic          rst;
    logic          load_valid;
    logic [AW-1:0] load_addr;
    logic [DW-1:0] load_data;
    logic          start;
    logic          busy;
    logic          done;
    elem_t         out;
    logic          out_valid;
    logic          out_ready;
    logic          bp_on;                  // Random back-pressure enable.
    logic [DW-1:0] mem_copy [RAM_DEPTH];   // What the RAM should hold.
    int            runs_done;
    int            elems_checked;
    int            error_count;

    tile_stream_top dut_i (.*);

    tile_checker checker_i (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Ready is redrawn every falling edge once back-pressure is on.
    initial begin
        out_ready = 1'b1;
        forever begin
            @(negedge clk);
            out_ready = !bp_on || ($urandom_range(99) < 60);
        end
    end

    initial begin
        #(LIMIT);
        $display("Timeout after %0d time units with %0d runs finished", LIMIT, runs_done);
        $display("Checks failed");
        $finish;
    end

    task automatic load_ram();
        int a;
        for (a = 0; a < RAM_DEPTH; a++) begin
            @(negedge clk);
            load_valid = 1'b1;
            load_addr  = AW'(a);
            load_data  = DW'($urandom);
            mem_copy[AW'(a)] = load_data; // Written at the next rising edge.
        end
        @(negedge clk);
        load_valid = 1'b0;
    endtask

    task automatic start_run();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    // Random writes and starts while busy. The DUT must drop all of them.
    task automatic poke_while_busy();
        int i;
        while (!busy) @(negedge clk);
        for (i = 0; i < 40; i++) begin
            load_valid = 1'($urandom_range(1));
            load_addr  = AW'($urandom_range(RAM_DEPTH - 1));
            load_data  = DW'($urandom);
            start      = 1'($urandom_range(1));
            @(negedge clk);
        end
        load_valid = 1'b0;
        start      = 1'b0;
    endtask

    // Polled on the falling edge, where the checker's counts are settled.
    task automatic wait_run(int n);
        while (runs_done < n) @(negedge clk);
    endtask

    initial begin
        void'($urandom(26));
        rst        = 1'b1;
        load_valid = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        start      = 1'b0;
        bp_on      = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        load_ram();
        start_run();
        wait_run(1);
        bp_on = 1'b1;
        start_run();
        wait_run(2);
        load_ram(); // Fresh contents for the restart.
        start_run();
        poke_while_busy();
        wait_run(3);
        repeat (20) @(posedge clk); // Room for a stray second done.
        $display("Totals: %0d runs, %0d elements, %0d check errors, %0d assertion failures",
                 runs_done, elems_checked, error_count, dut_i.props_i.fail_count);
        if (error_count == 0 && dut_i.props_i.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: bench/tile_checker.sv
// The model is built from mem_copy when a start is accepted, so the copy must be current by then.
module tile_checker import tile_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          start,
    input  logic          busy,
    input  logic          done,
    input  elem_t         out,
    input  logic          out_valid,
    input  logic          out_ready,
    input  logic [DW-1:0] mem_copy [RAM_DEPTH],
    output int            runs_done,
    output int            elems_checked,
    output int            error_count
);

    elem_t expect_q[$]; // Elements still owed by the current run.
    int    model_pads;  // Pads the model predicts for the run.
    int    seen_pads;
    int    errs_at_start;
    logic  armed;       // Set from an accepted start until done.

    // Walks the map in traversal order, output-channel tiles outermost.
    task automatic build_model();
        int nb;
        int mb;
        int rb;
        int cb;
        int k;
        int m;
        int r;
        int c;
        elem_t e;
        expect_q.delete();
        model_pads = 0;
        for (nb = 0; nb < FM_N; nb += TILE_N) begin
            for (mb = 0; mb < FM_M; mb += TILE_M) begin
                for (rb = 0; rb < FM_R; rb += ROW_STEP) begin
                    for (cb = 0; cb < FM_C; cb += COL_STEP) begin
                        for (k = 0; k < TILE_ELEMS; k++) begin
                            m = mb + k / (TILE_R * TILE_C); // Local channel is slowest.
                            r = rb + (k / TILE_C) % TILE_R;
                            c = cb + k % TILE_C;
                            e.pad = (m >= FM_M) || (r >= FM_R) || (c >= FM_C);
                            e.data = e.pad ? '0 : mem_copy[AW'(m * FM_R * FM_C + r * FM_C + c)];
                            e.n_base = CW'(nb);
                            e.m = CW'(m);
                            e.row = CW'(r);
                            e.col = CW'(c);
                            e.last_in_tile = (k == TILE_ELEMS - 1);
                            if (e.pad) model_pads++;
                            expect_q.push_back(e);
                        end
                    end
                end
            end
        end
    endtask

    task automatic check_field(string name, logic [7:0] want, logic [7:0] got);
        if (want !== got) begin
            $display("Error: out.%s expected 0x%02h got 0x%02h at element %0d",
                     name, want, got, elems_checked);
            error_count++;
        end
    endtask

    always @(posedge clk) begin
        elem_t want;
        if (rst) begin
            runs_done     = 0;
            elems_checked = 0;
            error_count   = 0;
            armed         = 1'b0;
        end else begin
            if (start && !busy) begin // Same acceptance rule as the DUT top level.
                build_model();
                armed         = 1'b1;
                seen_pads     = 0;
                errs_at_start = error_count;
            end
            if (out_valid && out_ready) begin
                if (!armed || expect_q.size() == 0) begin
                    $display("An element was transferred outside a run or past its end");
                    error_count++;
                end else begin
                    want = expect_q.pop_front();
                    check_field("data", want.data, out.data);
                    check_field("n_base", want.n_base, out.n_base);
                    check_field("m", want.m, out.m);
                    check_field("row", want.row, out.row);
                    check_field("col", want.col, out.col);
                    check_field("pad", CW'(want.pad), CW'(out.pad));
                    check_field("last_in_tile", CW'(want.last_in_tile), CW'(out.last_in_tile));
                    if (out.pad) seen_pads++;
                    elems_checked++;
                end
            end
            if (done) begin
                if (!armed) begin
                    $display("done pulsed while no run was in progress");
                    error_count++;
                end else begin
                    if (busy) begin
                        $display("busy was still high when done pulsed");
                        error_count++;
                    end
                    if (expect_q.size() != 0) begin
                        $display("done came with %0d elements still missing", expect_q.size());
                        error_count++;
                    end
                    if (seen_pads != model_pads) begin
                        $display("Error: pad count expected 0x%0h got 0x%0h", model_pads, seen_pads);
                        error_count++;
                    end
                    $display("Run %0d finished: %0d pads, %0d errors", runs_done + 1, seen_pads,
                             error_count - errs_at_start);
                    armed = 1'b0;
                    runs_done++;
                end
            end
        end
    end

endmodule

// File: bench/tile_props.sv
// Checks apply with rst low; reset values are checked one edge after rst is seen high.
module tile_props import tile_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  busy,
    input logic  done,
    input logic  out_valid,
    input logic  out_ready,
    input logic  desc_valid,
    input logic  tile_done,
    input elem_t out
);

    int fail_count = 0; // Number of failed assertions so far.

    // A stalled element must hold still until it is taken.
    stall_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out))
        else begin
            fail_count = fail_count + 1;
            $error("out changed or out_valid dropped while out_ready was low");
        end

    // Everything is idle one edge after reset is seen.
    reset_idle: assert property (@(posedge clk)
        rst |=> !out_valid && !busy && !done && !desc_valid && !tile_done)
        else begin
            fail_count = fail_count + 1;
            $error("Control outputs not idle after reset");
        end

    // The run is over when done fires. Nothing is left on the stream.
    done_idle: assert property (@(posedge clk) disable iff (rst)
        done |-> !busy && !out_valid)
        else begin
            fail_count = fail_count + 1;
            $error("busy or out_valid still high while done pulsed");
        end

endmodule

bind tile_stream_top tile_props props_i (.*);

// File: rtl/tile_stream_top.sv
// Loads and start pulses are dropped while busy; reload the RAM only between runs.
module tile_stream_top import tile_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          load_valid,
    input  logic [AW-1:0] load_addr,
    input  logic [DW-1:0] load_data,
    input  logic          start,
    output logic          busy,
    output logic          done,
    output elem_t         out,
    output logic          out_valid,
    input  logic          out_ready
);

    tile_t         desc;
    logic          desc_valid;
    logic          desc_ready;
    logic          tile_done;
    logic          rd_en;
    logic [AW-1:0] rd_addr;
    logic [DW-1:0] rd_data;
    logic          wr_en;
    logic          start_ok;

    assign wr_en    = load_valid && !busy; // No writes under a running fetch.
    assign start_ok = start && !busy;

    feature_ram ram_i (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (load_addr),
        .wr_data (load_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    tile_scheduler sched_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start_ok),
        .desc       (desc),
        .desc_valid (desc_valid),
        .desc_ready (desc_ready),
        .tile_done  (tile_done),
        .busy       (busy),
        .done       (done)
    );

    tile_fetcher fetch_i (
        .clk        (clk),
        .rst        (rst),
        .desc       (desc),
        .desc_valid (desc_valid),
        .desc_ready (desc_ready),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .out        (out),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .tile_done  (tile_done)
    );

endmodule

// File: rtl/tile_fetcher.sv
// Streams one tile at a time through a two-stage pipeline; positions past the map edge come out as zero pads.
module tile_fetcher import tile_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  tile_t         desc,
    input  logic          desc_valid,
    output logic          desc_ready,
    output logic          rd_en,
    output logic [AW-1:0] rd_addr,
    input  logic [DW-1:0] rd_data,
    output elem_t         out,
    output logic          out_valid,
    input  logic          out_ready,
    output logic          tile_done
);

    tile_t tile_q; // Descriptor of the tile being fetched.

    logic active;  // Set from descriptor accept until the last element leaves.
    logic issuing; // Set while elements of the tile remain to be issued.

    // Local position inside the tile, channel outermost.
    logic [CW-1:0] lm;
    logic [CW-1:0] lr;
    logic [CW-1:0] lc;

    // Absolute coordinates of the element at the issue stage.
    logic [CW-1:0] abs_m;
    logic [CW-1:0] abs_row;
    logic [CW-1:0] abs_col;

    logic issue_pad;
    logic issue_last;
    logic adv;        // Both stages move this cycle.
    logic issue_fire;

    elem_t s1_q;     // Issue stage, waiting for its RAM word.
    logic  s1_valid;
    elem_t out_q;    // Output register.

    assign desc_ready = !active;

    assign abs_m   = tile_q.base_m + lm;
    assign abs_row = tile_q.base_row + lr;
    assign abs_col = tile_q.base_col + lc;

    assign issue_pad = (abs_m >= CW'(FM_M)) || (abs_row >= CW'(FM_R)) ||
                       (abs_col >= CW'(FM_C));
    assign issue_last = (lm == CW'(TILE_M - 1)) && (lr == CW'(TILE_R - 1)) &&
                        (lc == CW'(TILE_C - 1));

    // The pipeline advances when the output register is empty or emptying.
    assign adv        = !out_valid || out_ready;
    assign issue_fire = adv && issuing;

    // Pads never touch the RAM.
    assign rd_en   = issue_fire && !issue_pad;
    assign rd_addr = AW'(abs_m) * PLANE_SIZE + AW'(abs_row) * ROW_SIZE + AW'(abs_col);

    assign out       = out_q;
    assign tile_done = out_valid && out_ready && out_q.last_in_tile;

    // Control state and counters.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active    <= 1'b0;
            issuing   <= 1'b0;
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
            lm        <= '0;
            lr        <= '0;
            lc        <= '0;
        end else begin
            if (desc_valid && desc_ready) begin
                active  <= 1'b1;
                issuing <= 1'b1;
                lm      <= '0;
                lr      <= '0;
                lc      <= '0;
            end
            if (tile_done) begin
                active <= 1'b0; // Ready for the next descriptor.
            end
            if (adv) begin
                out_valid <= s1_valid;
                s1_valid  <= issuing;
            end
            if (issue_fire) begin
                if (issue_last) begin
                    issuing <= 1'b0;
                end
                // Column fastest, then row, then channel.
                lc <= (lc == CW'(TILE_C - 1)) ? '0 : lc + 1'b1;
                if (lc == CW'(TILE_C - 1)) begin
                    lr <= (lr == CW'(TILE_R - 1)) ? '0 : lr + 1'b1;
                    if (lr == CW'(TILE_R - 1)) begin
                        lm <= lm + 1'b1;
                    end
                end
            end
        end
    end

    // Payload registers.
    always_ff @(posedge clk) begin
        if (desc_valid && desc_ready) begin
            tile_q <= desc;
        end
        if (adv) begin
            // The RAM word for s1_q arrived this cycle and holds while stalled.
            out_q      <= s1_q;
            out_q.data <= s1_q.pad ? '0 : rd_data;
            s1_q <= '{
                data:         '0,
                n_base:       tile_q.base_n,
                m:            abs_m,
                row:          abs_row,
                col:          abs_col,
                pad:          issue_pad,
                last_in_tile: issue_last
            };
        end
    end

endmodule

// File: rtl/tile_scheduler.sv
// One descriptor per tile in column, row, input channel, output channel order; start is ignored while busy.
module tile_scheduler import tile_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    output tile_t desc,
    output logic  desc_valid,
    input  logic  desc_ready,
    input  logic  tile_done,
    output logic  busy,
    output logic  done
);

    // Current tile bases. They only change on tile_done, so the descriptor
    // built from them holds steady until the fetcher takes it.
    logic [CW-1:0] base_n;
    logic [CW-1:0] base_m;
    logic [CW-1:0] base_row;
    logic [CW-1:0] base_col;

    // Last-value tests, one per loop level.
    logic last_n;
    logic last_m;
    logic last_row;
    logic last_col;
    logic final_tile;

    // A base is at its last value once one more step reaches the map edge.
    assign last_col = (base_col + CW'(COL_STEP)) >= CW'(FM_C);
    assign last_row = (base_row + CW'(ROW_STEP)) >= CW'(FM_R);
    assign last_m   = (base_m + CW'(TILE_M)) >= CW'(FM_M);
    assign last_n   = (base_n + CW'(TILE_N)) >= CW'(FM_N);

    assign final_tile = last_n && last_m && last_row && last_col; // Innermost to outermost all done.

    assign desc = '{
        base_n:     base_n,
        base_m:     base_m,
        base_row:   base_row,
        base_col:   base_col,
        final_tile: final_tile
    };

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy       <= 1'b0;
            done       <= 1'b0;
            desc_valid <= 1'b0;
            base_n     <= '0;
            base_m     <= '0;
            base_row   <= '0;
            base_col   <= '0;
        end else begin
            done <= 1'b0; // Single cycle pulse.
            if (start && !busy) begin
                // A new run always begins from the origin.
                busy       <= 1'b1;
                desc_valid <= 1'b1;
                base_n     <= '0;
                base_m     <= '0;
                base_row   <= '0;
                base_col   <= '0;
            end else if (busy) begin
                if (desc_valid && desc_ready) begin
                    desc_valid <= 1'b0; // Descriptor taken, wait for the tile to drain.
                end
                if (tile_done) begin
                    if (final_tile) begin
                        busy <= 1'b0;
                        done <= 1'b1;
                    end else begin
                        desc_valid <= 1'b1;
                        base_col   <= last_col ? '0 : base_col + CW'(COL_STEP);
                        // Each outer base moves only when every inner one wraps.
                        if (last_col) begin
                            base_row <= last_row ? '0 : base_row + CW'(ROW_STEP);
                        end
                        if (last_col && last_row) begin
                            base_m <= last_m ? '0 : base_m + CW'(TILE_M);
                        end
                        if (last_col && last_row && last_m) begin
                            base_n <= last_n ? '0 : base_n + CW'(TILE_N);
                        end
                    end
                end
            end
        end
    end

endmodule

// File: rtl/feature_ram.sv
// Single clock RAM with no reset; contents are undefined until loaded, reads have one cycle latency.
module feature_ram import tile_pkg::*; (
    input  logic          clk,
    input  logic          wr_en,
    input  logic [AW-1:0] wr_addr,
    input  logic [DW-1:0] wr_data,
    input  logic          rd_en,
    input  logic [AW-1:0] rd_addr,
    output logic [DW-1:0] rd_data
);

    // Feature map storage, channel-major then row then column.
    logic [DW-1:0] mem [RAM_DEPTH];

    // Load port from the top level.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data; // Address is assumed below RAM_DEPTH.
        end
    end

    // Registered read. The word stays put while rd_en is low, which lets the
    // fetcher stall without losing an element that is already in flight.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: rtl/tile_pkg.sv
// Sizes are fixed here for one map shape with stride 1; all coordinates must fit in CW bits.
package tile_pkg;

    // Feature map and tile sizes.
    localparam int FM_N   = 4; // Output channels.
    localparam int FM_M   = 3; // Input channels.
    localparam int FM_R   = 9; // Input rows.
    localparam int FM_C   = 9; // Input columns.
    localparam int TILE_N = 2; // Output channels covered by one tile.
    localparam int TILE_M = 2; // Input channels per tile.
    localparam int TILE_R = 4; // Tile height in rows.
    localparam int TILE_C = 4; // Tile width in columns.
    localparam int KERNEL = 3;
    localparam int STRIDE = 1;

    // Neighbouring tiles overlap by KERNEL-1, so the base step is the tile size
    // less that overlap, rounded down to a whole number of strides.
    localparam int ROW_STEP   = ((TILE_R + STRIDE - KERNEL) / STRIDE) * STRIDE;
    localparam int COL_STEP   = ((TILE_C + STRIDE - KERNEL) / STRIDE) * STRIDE;
    localparam int TILE_ELEMS = TILE_M * TILE_R * TILE_C; // 32 elements.
    localparam int RAM_DEPTH  = FM_M * FM_R * FM_C;       // 243 words.

    localparam int CW = 8; // Coordinate width.
    localparam int AW = 8; // RAM address width.
    localparam int DW = 8; // Data width.

    // Strides of the channel-major RAM layout, sized for address arithmetic.
    localparam logic [AW-1:0] PLANE_SIZE = AW'(FM_R * FM_C);
    localparam logic [AW-1:0] ROW_SIZE   = AW'(FM_C);

    // Tile descriptor handed from the scheduler to the fetcher.
    typedef struct packed {
        logic [CW-1:0] base_n;
        logic [CW-1:0] base_m;
        logic [CW-1:0] base_row;
        logic [CW-1:0] base_col;
        logic          final_tile; // Last tile of the run.
    } tile_t;

    // One element on the output stream, with absolute coordinates.
    typedef struct packed {
        logic [DW-1:0] data;
        logic [CW-1:0] n_base;       // Output-channel base of the owning tile.
        logic [CW-1:0] m;
        logic [CW-1:0] row;
        logic [CW-1:0] col;
        logic          pad;          // Zero-filled position outside the map.
        logic          last_in_tile;
    } elem_t;

endpackage
